//--- hw/periph_pkg.sv
// Peripheral subsystem package
// Wishbone widths, bus request and response structs, the address map
// and the register offset codes of the timers and interrupt controller

package periph_pkg;

    // ------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------
    localparam int WB_DWIDTH   = 32;
    localparam int WB_SWIDTH   = 4;
    localparam int WB_AWIDTH   = 32;
    localparam int TIMER_WIDTH = 16;

    // ------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------
    // Slave select field, one 4 KB region per slave
    localparam int REGION_MSB = 15;
    localparam int REGION_LSB = 12;
    localparam int REGION_W   = REGION_MSB - REGION_LSB + 1;

    typedef logic [REGION_W-1:0] region_t;

    // Timers occupy regions 0 and up, the interrupt controller sits at the top
    localparam region_t IRQ_REGION = 4'd15;

    // Master to slave, 71 bits
    typedef struct packed {
        logic [WB_AWIDTH-1:0] adr;
        logic [WB_SWIDTH-1:0] sel;
        logic                 we;
        logic [WB_DWIDTH-1:0] dat;
        logic                 cyc;
        logic                 stb;
    } wb_req_t;

    // Slave to master, 34 bits
    typedef struct packed {
        logic [WB_DWIDTH-1:0] dat;
        logic                 ack;
        logic                 err;
    } wb_rsp_t;

    // Register offsets, word address bits 3:2
    typedef enum logic [1:0] {
        TMR_LOAD  = 2'd0,
        TMR_VALUE = 2'd1,
        TMR_CTRL  = 2'd2,
        TMR_CLEAR = 2'd3
    } timer_reg_e;

    typedef enum logic [1:0] {
        IRQ_STATUS     = 2'd0,
        IRQ_RAW        = 2'd1,
        IRQ_ENABLE_SET = 2'd2,
        IRQ_ENABLE_CLR = 2'd3
    } irq_reg_e;

endpackage

//--- hw/wb_decoder.sv
// Wishbone address decoder
// Routes the master request to one timer or to the interrupt controller
// by address region, answers unmapped regions with an error and merges
// all slave responses back onto the master bus

`timescale 1ns/1ps

module wb_decoder
    import periph_pkg::*;
#(
    parameter int N_TIMERS = 3
) (
    input  logic    i_clk,
    input  logic    i_rst_n,

    // Master side
    input  wb_req_t i_wb,
    output wb_rsp_t o_wb,

    // Timer slaves
    output wb_req_t o_tmr_req [N_TIMERS],
    input  wb_rsp_t i_tmr_rsp [N_TIMERS],

    // Interrupt controller slave
    output wb_req_t o_irq_req,
    input  wb_rsp_t i_irq_rsp
);

    region_t               region;
    logic [N_TIMERS-1:0]   hit_tmr;
    logic                  hit_irq;
    logic                  unmapped;
    logic                  err_q;

    // ------------------------------------------------------------
    // Region decode
    // ------------------------------------------------------------
    always_comb begin
        region  = i_wb.adr[REGION_MSB:REGION_LSB];
        hit_irq = (region == IRQ_REGION);
        for (int i = 0; i < N_TIMERS; i++) begin
            hit_tmr[i] = (region == region_t'(i));
        end
        unmapped = !hit_irq && (hit_tmr == '0);
    end

    // Only the selected slave sees cyc and stb
    always_comb begin
        for (int i = 0; i < N_TIMERS; i++) begin
            o_tmr_req[i]     = i_wb;
            o_tmr_req[i].cyc = i_wb.cyc & hit_tmr[i];
            o_tmr_req[i].stb = i_wb.stb & hit_tmr[i];
        end
        o_irq_req     = i_wb;
        o_irq_req.cyc = i_wb.cyc & hit_irq;
        o_irq_req.stb = i_wb.stb & hit_irq;
    end

    // ------------------------------------------------------------
    // Unmapped access error
    // ------------------------------------------------------------
    // One cycle pulse, low again on the following cycle
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            err_q <= 1'b0;
        end else begin
            err_q <= unmapped & i_wb.cyc & i_wb.stb & ~err_q;
        end
    end

    // Response merge
    // Idle slaves drive zeros, so a plain OR is enough
    always_comb begin
        o_wb     = i_irq_rsp;
        for (int i = 0; i < N_TIMERS; i++) begin
            o_wb.dat = o_wb.dat | i_tmr_rsp[i].dat;
            o_wb.ack = o_wb.ack | i_tmr_rsp[i].ack;
            o_wb.err = o_wb.err | i_tmr_rsp[i].err;
        end
        o_wb.err = o_wb.err | err_q;
    end

endmodule

//--- hw/interval_timer.sv
// Interval timer
// Down counter reloaded from LOAD on expiry, which also raises a sticky
// interrupt. Registers are LOAD, VALUE, CTRL and CLEAR on Wishbone

`timescale 1ns/1ps

module interval_timer
    import periph_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst_n,

    input  wb_req_t i_wb,
    output wb_rsp_t o_wb,

    output logic    o_int
);

    timer_reg_e             reg_sel;
    logic                   access;
    logic                   wr;
    logic                   ack_q;
    logic [WB_DWIDTH-1:0]   rd_q;
    logic [TIMER_WIDTH-1:0] load_q;
    logic [TIMER_WIDTH-1:0] load_nxt;
    logic [TIMER_WIDTH-1:0] count_q;
    logic                   enable_q;
    logic                   int_q;

    // New request only, the cycle after an ack is ignored
    assign access  = i_wb.cyc & i_wb.stb & ~ack_q;
    assign wr      = access & i_wb.we;
    assign reg_sel = timer_reg_e'(i_wb.adr[3:2]);

    // Byte lanes of the LOAD write
    assign load_nxt[7:0]  = i_wb.sel[0] ? i_wb.dat[7:0]  : load_q[7:0];
    assign load_nxt[15:8] = i_wb.sel[1] ? i_wb.dat[15:8] : load_q[15:8];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            ack_q    <= 1'b0;
            load_q   <= '0;
            count_q  <= '0;
            enable_q <= 1'b0;
            int_q    <= 1'b0;
        end else begin
            ack_q <= access;

            // Count down, on zero flag the interrupt and reload
            if (enable_q) begin
                if (count_q == '0) begin
                    int_q   <= 1'b1;
                    count_q <= load_q;
                end else begin
                    count_q <= count_q - 1'b1;
                end
            end

            if (wr) begin
                case (reg_sel)
                    TMR_LOAD: begin
                        load_q  <= load_nxt;
                        count_q <= load_nxt;
                    end
                    TMR_CTRL:  if (i_wb.sel[0]) enable_q <= i_wb.dat[0];
                    TMR_CLEAR: int_q <= 1'b0;
                    default: ;
                endcase
            end
        end
    end

    // Read data captured with the access
    always_ff @(posedge i_clk) begin
        if (access && !i_wb.we) begin
            case (reg_sel)
                TMR_LOAD:  rd_q <= WB_DWIDTH'(load_q);
                TMR_VALUE: rd_q <= WB_DWIDTH'(count_q);
                TMR_CTRL:  rd_q <= WB_DWIDTH'(enable_q);
                default:   rd_q <= '0;
            endcase
        end
    end

    assign o_wb.dat = ack_q ? rd_q : '0;
    assign o_wb.ack = ack_q;
    assign o_wb.err = 1'b0;
    assign o_int    = int_q;

endmodule

//--- hw/irq_controller.sv
// Interrupt controller
// Samples the timer interrupt lines into a raw status register, masks
// them with an enable register and drives a single registered IRQ

`timescale 1ns/1ps

module irq_controller
    import periph_pkg::*;
#(
    parameter int N_TIMERS = 3
) (
    input  logic                i_clk,
    input  logic                i_rst_n,

    input  wb_req_t             i_wb,
    output wb_rsp_t             o_wb,

    input  logic [N_TIMERS-1:0] i_tmr_int,
    output logic                o_irq
);

    irq_reg_e              reg_sel;
    logic                  access;
    logic                  wr;
    logic                  ack_q;
    logic [WB_DWIDTH-1:0]  rd_q;
    logic [N_TIMERS-1:0]   raw_q;
    logic [N_TIMERS-1:0]   mask_q;
    logic [N_TIMERS-1:0]   status;
    logic                  irq_q;

    assign access  = i_wb.cyc & i_wb.stb & ~ack_q;
    assign wr      = access & i_wb.we;
    assign reg_sel = irq_reg_e'(i_wb.adr[3:2]);
    assign status  = raw_q & mask_q;

    // ------------------------------------------------------------
    // Status, mask and IRQ output
    // ------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            ack_q  <= 1'b0;
            raw_q  <= '0;
            mask_q <= '0;
            irq_q  <= 1'b0;
        end else begin
            ack_q <= access;
            // Raw bits track the timer lines one cycle late
            raw_q <= i_tmr_int;
            irq_q <= |status;

            // At most eight sources, all in the low byte
            if (wr && i_wb.sel[0]) begin
                case (reg_sel)
                    IRQ_ENABLE_SET: mask_q <= mask_q | i_wb.dat[N_TIMERS-1:0];
                    IRQ_ENABLE_CLR: mask_q <= mask_q & ~i_wb.dat[N_TIMERS-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Read data captured with the access
    always_ff @(posedge i_clk) begin
        if (access && !i_wb.we) begin
            case (reg_sel)
                IRQ_STATUS:     rd_q <= WB_DWIDTH'(status);
                IRQ_RAW:        rd_q <= WB_DWIDTH'(raw_q);
                IRQ_ENABLE_SET: rd_q <= WB_DWIDTH'(mask_q);
                default:        rd_q <= '0;
            endcase
        end
    end

    assign o_wb.dat = ack_q ? rd_q : '0;
    assign o_wb.ack = ack_q;
    assign o_wb.err = 1'b0;
    assign o_irq    = irq_q;

endmodule

//--- hw/periph_soc.sv
// Wishbone peripheral subsystem top level
// Address decoder, a bank of interval timers and the interrupt
// controller that collects their interrupts into one IRQ

`timescale 1ns/1ps

module periph_soc
    import periph_pkg::*;
#(
    parameter int N_TIMERS = 3
) (
    input  logic    i_clk,
    input  logic    i_rst_n,

    input  wb_req_t i_wb,
    output wb_rsp_t o_wb,

    output logic    o_irq
);

    wb_req_t             tmr_req [N_TIMERS];
    wb_rsp_t             tmr_rsp [N_TIMERS];
    wb_req_t             irq_req;
    wb_rsp_t             irq_rsp;
    logic [N_TIMERS-1:0] tmr_int;

    // ------------------------------------------------------------
    // Address decoder
    // ------------------------------------------------------------
    wb_decoder #(
        .N_TIMERS  ( N_TIMERS )
    ) u_wb_decoder (
        .i_clk     ( i_clk    ),
        .i_rst_n   ( i_rst_n  ),
        .i_wb      ( i_wb     ),
        .o_wb      ( o_wb     ),
        .o_tmr_req ( tmr_req  ),
        .i_tmr_rsp ( tmr_rsp  ),
        .o_irq_req ( irq_req  ),
        .i_irq_rsp ( irq_rsp  )
    );

    // One timer per region, interrupt bit i from timer i
    for (genvar i = 0; i < N_TIMERS; i++) begin : g_timer
        interval_timer u_timer (
            .i_clk   ( i_clk      ),
            .i_rst_n ( i_rst_n    ),
            .i_wb    ( tmr_req[i] ),
            .o_wb    ( tmr_rsp[i] ),
            .o_int   ( tmr_int[i] )
        );
    end

    // ------------------------------------------------------------
    // Interrupt controller
    // ------------------------------------------------------------
    irq_controller #(
        .N_TIMERS  ( N_TIMERS )
    ) u_irq_controller (
        .i_clk     ( i_clk    ),
        .i_rst_n   ( i_rst_n  ),
        .i_wb      ( irq_req  ),
        .o_wb      ( irq_rsp  ),
        .i_tmr_int ( tmr_int  ),
        .o_irq     ( o_irq    )
    );

endmodule

//--- tb/periph_tests.svh
// Stimulus and expected-value table of the peripheral subsystem testbench
// Timer i sits at region i, the interrupt controller at region 15
// Reads: name, address, expected data, expected err
// Writes: name, address, sel, write data, expected err

`ifndef PERIPH_TESTS_SVH
`define PERIPH_TESTS_SVH

task automatic fill_table();
    // Reset state
    add_read("t0 load after reset",   32'h0000_0000, 32'h0000_0000, 1'b0);
    add_read("t0 value after reset",  32'h0000_0004, 32'h0000_0000, 1'b0);
    add_read("t0 ctrl after reset",   32'h0000_0008, 32'h0000_0000, 1'b0);
    add_read("t1 load after reset",   32'h0000_1000, 32'h0000_0000, 1'b0);
    add_read("t1 value after reset",  32'h0000_1004, 32'h0000_0000, 1'b0);
    add_read("t1 ctrl after reset",   32'h0000_1008, 32'h0000_0000, 1'b0);
    add_read("t2 load after reset",   32'h0000_2000, 32'h0000_0000, 1'b0);
    add_read("t2 value after reset",  32'h0000_2004, 32'h0000_0000, 1'b0);
    add_read("t2 ctrl after reset",   32'h0000_2008, 32'h0000_0000, 1'b0);
    add_read("irq raw after reset",   32'h0000_F004, 32'h0000_0000, 1'b0);
    add_read("irq status after reset", 32'h0000_F000, 32'h0000_0000, 1'b0);
    add_irq_check("irq low after reset", 1'b0);

    // Byte selects, lane 0 only for the second write
    add_write("t0 load full word",    32'h0000_0000, 4'hF, 32'h0000_1234, 1'b0);
    add_read("t0 load readback",      32'h0000_0000, 32'h0000_1234, 1'b0);
    add_write("t0 load low byte",     32'h0000_0000, 4'h1, 32'h5A5A_5AAB, 1'b0);
    add_read("t0 load merged",        32'h0000_0000, 32'h0000_12AB, 1'b0);
    add_read("t0 value follows load", 32'h0000_0004, 32'h0000_12AB, 1'b0);
    add_write("t2 load full word",    32'h0000_2000, 4'hF, 32'h0000_0F0F, 1'b0);
    add_read("t2 load readback",      32'h0000_2000, 32'h0000_0F0F, 1'b0);
    add_read("t0 load kept",          32'h0000_0000, 32'h0000_12AB, 1'b0);
    add_read("t1 load untouched",     32'h0000_1000, 32'h0000_0000, 1'b0);

    // Unmapped region 5
    add_read("region 5 read",         32'h0000_5000, 32'h0000_0000, 1'b1);
    add_write("region 5 write",       32'h0000_5004, 4'hF, 32'hDEAD_BEEF, 1'b1);
    add_read("mapped after error",    32'h0000_0000, 32'h0000_12AB, 1'b0);

    // Timer 1 expiry, interrupt after LOAD+1 cycles
    add_write("t1 load 10",           32'h0000_1000, 4'hF, 32'd10, 1'b0);
    add_write("t1 enable",            32'h0000_1008, 4'hF, 32'd1, 1'b0);
    add_wait("t1 count down", 30);
    add_read("irq raw t1 only",       32'h0000_F004, 32'h0000_0002, 1'b0);
    add_write("t1 disable",           32'h0000_1008, 4'hF, 32'd0, 1'b0);
    add_write("t1 clear",             32'h0000_100C, 4'hF, 32'd0, 1'b0);
    add_read("irq raw cleared",       32'h0000_F004, 32'h0000_0000, 1'b0);

    // Masking with timer 2
    add_write("t2 load 4",            32'h0000_2000, 4'hF, 32'd4, 1'b0);
    add_write("t2 enable",            32'h0000_2008, 4'hF, 32'd1, 1'b0);
    add_wait("t2 count down", 15);
    add_read("irq raw t2",            32'h0000_F004, 32'h0000_0004, 1'b0);
    add_irq_check("irq masked off", 1'b0);
    add_read("status masked",         32'h0000_F000, 32'h0000_0000, 1'b0);
    add_write("enable set bit 2",     32'h0000_F008, 4'hF, 32'h0000_0004, 1'b0);
    add_wait("irq settle on", 2);
    add_irq_check("irq raised", 1'b1);
    add_read("status bit 2",          32'h0000_F000, 32'h0000_0004, 1'b0);
    add_write("enable clear bit 2",   32'h0000_F00C, 4'hF, 32'h0000_0004, 1'b0);
    add_wait("irq settle off", 2);
    add_irq_check("irq dropped", 1'b0);
    add_read("status after clear",    32'h0000_F000, 32'h0000_0000, 1'b0);
endtask

`endif

//--- tb/periph_soc_tb.sv
// Testbench of the Wishbone peripheral subsystem
// Applies the stimulus table row by row as single Wishbone transfers,
// waits or IRQ checks, and compares every response with the table

`timescale 1ns/1ps

module periph_soc_tb
    import periph_pkg::*;
();

    typedef enum logic [1:0] {
        OP_WRITE,
        OP_READ,
        OP_WAIT,
        OP_IRQ
    } op_e;

    // One row of the table
    // Row names live in a queue of their own
    typedef struct packed {
        op_e                  op;
        logic [WB_AWIDTH-1:0] adr;
        logic [WB_SWIDTH-1:0] sel;
        logic [WB_DWIDTH-1:0] wdat;
        wb_rsp_t              exp_rsp;
        logic                 exp_irq;
    } test_row_t;

    logic      clk = 1'b0;
    logic      rst_n;
    wb_req_t   wb_req;
    wb_rsp_t   wb_rsp;
    logic      irq;

    test_row_t rows[$];
    string     row_names[$];
    int        pass_count  = 0;
    int        fail_count  = 0;
    int        cycle_count = 0;
    int        cycle_limit = 0;

    periph_soc #(
        .N_TIMERS ( 3      )
    ) uut (
        .i_clk    ( clk    ),
        .i_rst_n  ( rst_n  ),
        .i_wb     ( wb_req ),
        .o_wb     ( wb_rsp ),
        .o_irq    ( irq    )
    );

    always #4 clk = ~clk;

    // Stops the run once the cycle limit is reached
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run went past %0d cycles", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Table building
    // ------------------------------------------------------------
    task automatic add_row(input string name, input op_e op, input logic [31:0] adr,
                           input logic [3:0] sel, input logic [31:0] wdat,
                           input logic [31:0] exp_dat, input logic exp_err,
                           input logic exp_irq);
        test_row_t row;
        row.op          = op;
        row.adr         = adr;
        row.sel         = sel;
        row.wdat        = wdat;
        row.exp_rsp.dat = exp_dat;
        row.exp_rsp.ack = ~exp_err;
        row.exp_rsp.err = exp_err;
        row.exp_irq     = exp_irq;
        rows.push_back(row);
        row_names.push_back(name);
    endtask

    task automatic add_write(input string name, input logic [31:0] adr,
                             input logic [3:0] sel, input logic [31:0] dat,
                             input logic exp_err);
        add_row(name, OP_WRITE, adr, sel, dat, '0, exp_err, 1'b0);
    endtask

    task automatic add_read(input string name, input logic [31:0] adr,
                            input logic [31:0] exp_dat, input logic exp_err);
        add_row(name, OP_READ, adr, 4'hF, '0, exp_dat, exp_err, 1'b0);
    endtask

    task automatic add_wait(input string name, input int cycles);
        add_row(name, OP_WAIT, '0, '0, cycles, '0, 1'b0, 1'b0);
    endtask

    task automatic add_irq_check(input string name, input logic level);
        add_row(name, OP_IRQ, '0, '0, '0, '0, 1'b0, level);
    endtask

    `include "periph_tests.svh"

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_rsp(input string name, input wb_rsp_t exp, input wb_rsp_t act);
        if (act !== exp) begin
            $display("Error %s: expected dat=%h ack=%b err=%b, got dat=%h ack=%b err=%b",
                     name, exp.dat, exp.ack, exp.err, act.dat, act.ack, act.err);
            fail_count++;
        end else begin
            $display("ok    %s", name);
            pass_count++;
        end
    endtask

    task automatic check_irq(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error %s: expected irq=%b, got irq=%b", name, exp, act);
            fail_count++;
        end else begin
            $display("ok    %s", name);
            pass_count++;
        end
    endtask

    // One classic Wishbone transfer that starts and ends on a falling edge
    task automatic bus_access(input test_row_t row, output wb_rsp_t rsp, output logic seen);
        seen       = 1'b0;
        rsp        = '0;
        wb_req.adr = row.adr;
        wb_req.sel = row.sel;
        wb_req.we  = (row.op == OP_WRITE);
        wb_req.dat = row.wdat;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        for (int c = 0; c < 4 && !seen; c++) begin
            @(negedge clk);
            if (wb_rsp.ack || wb_rsp.err) begin
                seen = 1'b1;
                rsp  = wb_rsp;
            end
        end
        // Idle for one cycle before the next request
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
        @(negedge clk);
    endtask

    task automatic run_row(input int k);
        test_row_t row;
        wb_rsp_t   got;
        logic      seen;
        row = rows[k];
        case (row.op)
            OP_WAIT: begin
                repeat (row.wdat) @(negedge clk);
                $display("wait  %s: %0d cycles", row_names[k], row.wdat);
            end
            OP_IRQ: check_irq(row_names[k], row.exp_irq, irq);
            default: begin
                bus_access(row, got, seen);
                if (!seen) begin
                    $display("%s: no bus response within 4 cycles", row_names[k]);
                    fail_count++;
                end else begin
                    // Write acks carry no defined read data
                    // An error response still has to return zero data
                    if (row.op == OP_WRITE && !row.exp_rsp.err) got.dat = '0;
                    check_rsp(row_names[k], row.exp_rsp, got);
                end
            end
        endcase
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        rst_n  = 1'b0;
        wb_req = '0;
        fill_table();
        cycle_limit = rows.size() * 8 + 100;
        foreach (rows[k]) begin
            if (rows[k].op == OP_WAIT) cycle_limit += rows[k].wdat;
        end

        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        foreach (rows[k]) begin
            run_row(k);
        end

        $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- periph_soc.f
+incdir+tb
hw/periph_pkg.sv
hw/wb_decoder.sv
hw/interval_timer.sv
hw/irq_controller.sv
hw/periph_soc.sv
tb/periph_soc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the peripheral subsystem testbench with Verilator and run it.
# The exit status is 0 only when the pass message shows up in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f periph_soc.f \
    --top-module periph_soc_tb -o sim_periph_soc \
    || { echo "Build failed"; exit 1; }

sim_out="$(./obj_dir/sim_periph_soc)"
echo "$sim_out"

echo "$sim_out" | grep -q "All tests passed" \
    && { echo "Simulation result: pass"; exit 0; } \
    || { echo "Simulation result: fail"; exit 1; }
